/* pic.f */
+incdir+verif
hdl/pic_pkg.sv
hdl/pic_config.sv
hdl/pic_source_select.sv
hdl/pic_service_fsm.sv
hdl/pic_top.sv
verif/pic_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module pic_tb -f pic.f -o pic_sim

# A failing run exits nonzero, its output is still shown before the search.
out=$(./obj_dir/pic_sim 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qxF '** PASS **'

/* verif/pic_tb_ref.svh */
// ----------------------------------------------------------------------
// Reference model.
// ----------------------------------------------------------------------

// Source the controller should signal next. Prio mode walks the table from
// slot 0, poll mode walks the sources from the last served one onward.
function automatic src_id_t expected_id(pic_mode_e mode, src_id_t [N_SRC-1:0] ptab,
                                        logic [N_SRC-1:0] rq, src_id_t last);
    logic    hit;
    src_id_t idx;
    hit         = 1'b0;
    expected_id = '0;
    for (int k = 0; k < N_SRC; k++) begin
        if (mode == MODE_PRIO) begin
            idx = ptab[src_id_t'(k)];           // Table order.
        end else begin
            idx = last + src_id_t'(k);          // Cyclic, wraps past 7.
        end
        if (!hit && rq[idx]) begin
            hit         = 1'b1;
            expected_id = idx;
        end
    end
endfunction

// ----------------------------------------------------------------------
// Compare tasks.
// ----------------------------------------------------------------------

task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "Simulation stopped at the first error.");
endtask

task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
    if (got !== exp) begin
        $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
        abort_run();
    end
endtask

// ----------------------------------------------------------------------
// Processor side.
// ----------------------------------------------------------------------

// Inputs change a little after the rising edge.
task automatic next_cycle();
    @(posedge clock_in);
    #1;
endtask

// One strobed command word.
task automatic send_cmd(input src_id_t hi, input src_id_t lo, input logic [1:0] cmd);
    bus_in.as_cmd.hi_entry = hi;
    bus_in.as_cmd.lo_entry = lo;
    bus_in.as_cmd.cmd      = cmd;
    cmd_valid              = 1'b1;
    next_cycle();
    cmd_valid = 1'b0;
    bus_in    = '0;
endtask

// Full four-phase service, with back-pressure on every step.
task automatic serve(input bus_word_t exp_vec, input bus_word_t done_vec, input rq_t next_rq);
    exp_q.push_back(exp_vec);                   // For the vector monitor.
    while (intr_out !== 1'b1) begin
        next_cycle();
    end
    check_bit("bus_oe", bus_oe, 1'b0);
    repeat (3) begin
        next_cycle();
        check_bit("intr_out", intr_out, 1'b1);  // No ack yet, line stays up.
    end
    cpu_ack = 1'b1;                             // First acknowledge.
    next_cycle();
    check_bit("intr_out", intr_out, 1'b0);
    check_bit("bus_oe", bus_oe, 1'b1);
    repeat (3) begin
        next_cycle();
        check_bit("bus_oe", bus_oe, 1'b1);      // Ack held high, nothing moves.
        check_word("bus_out", bus_out, exp_vec);
    end
    cpu_ack = 1'b0;
    repeat (2) begin
        next_cycle();
        check_bit("bus_oe", bus_oe, 1'b1);
    end
    cpu_ack = 1'b1;                             // Second acknowledge takes the vector.
    next_cycle();
    check_bit("bus_oe", bus_oe, 1'b0);
    next_cycle();
    check_bit("intr_out", intr_out, 1'b0);
    cpu_ack = 1'b0;
    next_cycle();                               // Now waiting for the done word.
    intr_rq = next_rq;
    next_cycle();
    bus_in  = done_vec;
    cpu_ack = 1'b1;
    next_cycle();
    cpu_ack = 1'b0;
    bus_in  = '0;
endtask

/* verif/pic_tb.sv */
module pic_tb
    import pic_pkg::*;
();

    localparam int unsigned SEED           = 32'h5cd80473;
    localparam int          N_POLL_RUNS    = 24;
    localparam int          N_PRIO_RUNS    = 24;
    localparam int          N_REPOLL_RUNS  = 8;
    localparam int          QUIET_CYCLES   = 20;
    localparam int          TIMEOUT_CYCLES = 6000;   // About four times the full run.

    typedef logic [N_SRC-1:0] rq_t;

    logic      clock_in;
    logic      rst_in;
    rq_t       intr_rq;
    bus_word_t bus_in;
    logic      cmd_valid;
    logic      cpu_ack;
    logic      intr_out;
    bus_word_t bus_out;
    logic      bus_oe;

    bus_word_t           exp_q[$];                  // Vector words still to be seen.
    int                  cycles = 0;
    int                  n_vec  = 0;                // Vector words compared.
    logic                oe_seen = 1'b0;
    logic                oe_rise;
    pic_mode_e           mode;                      // Mode the DUT should be in.
    src_id_t [N_SRC-1:0] ptab;                      // Table sent to the DUT.
    src_id_t             last;                      // Last served source in poll mode.
    rq_t                 cur_rq;

    `include "pic_tb_ref.svh"

    pic_top i_dut (
        .clock_in  (clock_in),
        .rst_in    (rst_in),
        .intr_rq   (intr_rq),
        .bus_in    (bus_in),
        .cmd_valid (cmd_valid),
        .cpu_ack   (cpu_ack),
        .intr_out  (intr_out),
        .bus_out   (bus_out),
        .bus_oe    (bus_oe)
    );

    initial begin
        clock_in = 1'b0;
        forever #5 clock_in = ~clock_in;
    end

    always @(posedge clock_in) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // Compares each vector word when the DUT starts offering it.
    always @(negedge clock_in) begin
        oe_rise = bus_oe && !oe_seen && !rst_in;
        oe_seen = bus_oe;
        if (oe_rise && (exp_q.size() == 0)) begin
            $display("The DUT offered a vector word while no service was expected.");
            abort_run();
        end else if (oe_rise) begin
            check_word("bus_out", bus_out, exp_q.pop_front());
            n_vec = n_vec + 1;
        end
    end

    // ------------------------------------------------------------------
    // Stimulus helpers.
    // ------------------------------------------------------------------

    // New request set for the next service that never leaves it idle.
    function automatic rq_t next_requests(src_id_t served);
        rq_t     r;
        src_id_t slot;
        r    = rq_t'($urandom());
        slot = src_id_t'($urandom_range(N_SRC - 1, 0));
        if (mode == MODE_PRIO) begin
            r[ptab[slot]] = 1'b1;               // Some table entry stays active.
        end else begin
            r[served] = 1'b0;                   // Served source has dropped.
            if (r == '0) begin
                r[served + 3'd1] = 1'b1;
            end
        end
        return r;
    endfunction

    task automatic run_services(input int count, input logic bad_last);
        src_id_t   id;
        bus_word_t exp_vec;
        bus_word_t done_vec;
        rq_t       next_rq;
        for (int n = 0; n < count; n++) begin
            id                    = expected_id(mode, ptab, cur_rq, last);
            exp_vec.as_vec.code   = (mode == MODE_PRIO) ? VEC_CODE_PRIO : VEC_CODE_POLL;
            exp_vec.as_vec.id     = id;
            done_vec.as_vec.code  = (mode == MODE_PRIO) ? DONE_CODE_PRIO : DONE_CODE_POLL;
            done_vec.as_vec.id    = id;
            if (bad_last && (n == count - 1)) begin
                done_vec.as_vec.code = ~done_vec.as_vec.code;   // Wrong done code.
            end
            next_rq = next_requests(id);
            serve(exp_vec, done_vec, next_rq);
            last   = id;
            cur_rq = next_rq;
        end
    endtask

    task automatic expect_quiet();
        repeat (QUIET_CYCLES) begin
            next_cycle();
            check_bit("intr_out", intr_out, 1'b0);
        end
    endtask

    task automatic start_polling();
        send_cmd('0, '0, CMD_POLL);
        mode = MODE_POLL;
        last = '0;                              // Scan restarts at source 0.
    endtask

    task automatic load_table();
        for (int k = 0; k < N_SRC; k++) begin
            ptab[src_id_t'(k)] = src_id_t'($urandom_range(N_SRC - 1, 0));
        end
        for (int w = 0; w < N_CMD_WORDS; w++) begin
            send_cmd(ptab[src_id_t'(2 * w)], ptab[src_id_t'(2 * w + 1)], CMD_PRIO);
        end
        mode    = MODE_PRIO;
        cur_rq  = next_requests('0);            // First scan sees a table entry.
        intr_rq = cur_rq;
    endtask

    // ------------------------------------------------------------------
    // Scenarios.
    // ------------------------------------------------------------------

    initial begin
        void'($urandom(SEED));
        rst_in    = 1'b1;
        intr_rq   = '0;
        bus_in    = '0;
        cmd_valid = 1'b0;
        cpu_ack   = 1'b0;
        mode      = MODE_NONE;
        ptab      = '0;
        last      = '0;
        repeat (3) @(posedge clock_in);
        #1;
        rst_in = 1'b0;
        check_bit("intr_out", intr_out, 1'b0);
        check_bit("bus_oe", bus_oe, 1'b0);
        cur_rq  = rq_t'($urandom_range((1 << N_SRC) - 1, 1));
        intr_rq = cur_rq;
        expect_quiet();                         // Active requests without a mode.
        send_cmd('0, '0, 2'd3);                 // Unknown command is ignored.
        expect_quiet();
        start_polling();
        run_services(N_POLL_RUNS, 1'b1);
        mode = MODE_NONE;                       // Bad done word cleared the setup.
        expect_quiet();
        load_table();
        run_services(N_PRIO_RUNS, 1'b1);
        mode = MODE_NONE;
        expect_quiet();
        start_polling();
        run_services(N_REPOLL_RUNS, 1'b0);
        if ((exp_q.size() == 0) && (n_vec == N_POLL_RUNS + N_PRIO_RUNS + N_REPOLL_RUNS)) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("The DUT did not offer every expected vector word.");
            abort_run();
        end
    end

endmodule

/* hdl/pic_top.sv */
module pic_top
    import pic_pkg::*;
(
    input  logic             clock_in,
    input  logic             rst_in,
    input  logic [N_SRC-1:0] intr_rq,       // Request levels from the sources.
    input  bus_word_t        bus_in,        // Word from the processor.
    input  logic             cmd_valid,     // Strobe for command words.
    input  logic             cpu_ack,       // Acknowledge level.
    output logic             intr_out,      // Interrupt line to the processor.
    output bus_word_t        bus_out,       // Vector word to the processor.
    output logic             bus_oe         // bus_out is valid.
);

    pic_cfg_t cfg;                          // Mode and priority table.
    pic_sel_t sel;                          // Next source to signal.
    logic     cfg_clear;                    // Bad done word, drop the setup.
    logic     scan_en;                      // FSM is idle and looking.

    // ------------------------------------------------------------------
    // Configuration registers.
    // ------------------------------------------------------------------

    pic_config i_config (
        .clock_in  (clock_in),
        .rst_in    (rst_in),
        .bus_in    (bus_in),
        .cmd_valid (cmd_valid),
        .cfg_clear (cfg_clear),
        .cfg       (cfg)
    );

    // ------------------------------------------------------------------
    // Source selection and service handshake.
    // ------------------------------------------------------------------

    pic_source_select i_select (
        .clock_in (clock_in),
        .rst_in   (rst_in),
        .cfg      (cfg),
        .intr_rq  (intr_rq),
        .scan_en  (scan_en),
        .sel      (sel)
    );

    pic_service_fsm i_fsm (
        .clock_in  (clock_in),
        .rst_in    (rst_in),
        .cfg       (cfg),
        .sel       (sel),
        .cpu_ack   (cpu_ack),
        .bus_in    (bus_in),
        .scan_en   (scan_en),
        .cfg_clear (cfg_clear),
        .intr_out  (intr_out),
        .bus_out   (bus_out),
        .bus_oe    (bus_oe)
    );

endmodule

/* hdl/pic_service_fsm.sv */
module pic_service_fsm
    import pic_pkg::*;
(
    input  logic      clock_in,
    input  logic      rst_in,
    input  pic_cfg_t  cfg,
    input  pic_sel_t  sel,                  // Candidate from the selector.
    input  logic      cpu_ack,              // Processor acknowledge level.
    input  bus_word_t bus_in,               // Done word, read as a vector.
    output logic      scan_en,              // High in scan.
    output logic      cfg_clear,            // Bad done word.
    output logic      intr_out,
    output bus_word_t bus_out,
    output logic      bus_oe
);

    typedef enum logic [2:0] {
        ST_SCAN      = 3'd0,                // Look for a source.
        ST_WAIT_ACK1 = 3'd1,                // intr_out high.
        ST_WAIT_REL1 = 3'd2,
        ST_WAIT_ACK2 = 3'd3,                // Vector on the bus.
        ST_WAIT_REL2 = 3'd4,
        ST_WAIT_DONE = 3'd5                 // Service routine running.
    } state_e;

    state_e            state;
    src_id_t           served_id;           // Source in service.
    vec_word_t         vec_word;            // Outgoing vector.
    vec_word_t         done_word;           // Incoming done word.
    logic [CODE_W-1:0] done_code;           // Expected code for this mode.
    logic              done_ok;

    // ------------------------------------------------------------------
    // Vector build and done check.
    // ------------------------------------------------------------------

    always_comb begin
        if (cfg.mode == MODE_POLL) begin
            vec_word.code = VEC_CODE_POLL;
            done_code     = DONE_CODE_POLL;
        end else begin
            vec_word.code = VEC_CODE_PRIO;
            done_code     = DONE_CODE_PRIO;
        end
        vec_word.id = served_id;
    end

    assign done_word = bus_in.as_vec;
    assign done_ok   = (done_word.code == done_code) && (done_word.id == served_id);

    assign scan_en   = (state == ST_SCAN);
    assign cfg_clear = (state == ST_WAIT_DONE) && cpu_ack && !done_ok;   // Same edge as exit.

    // ------------------------------------------------------------------
    // Handshake.
    // ------------------------------------------------------------------

    // Each ack step waits for the level, each release step waits for it to drop.
    always_ff @(posedge clock_in or posedge rst_in) begin
        if (rst_in) begin
            state    <= ST_SCAN;
            intr_out <= 1'b0;
            bus_oe   <= 1'b0;
        end else begin
            case (state)
                ST_SCAN: begin
                    if (sel.found) begin
                        state    <= ST_WAIT_ACK1;
                        intr_out <= 1'b1;   // Raise the interrupt.
                    end
                end
                ST_WAIT_ACK1: begin
                    if (cpu_ack) begin
                        state    <= ST_WAIT_REL1;
                        intr_out <= 1'b0;
                        bus_oe   <= 1'b1;   // Vector goes out with it.
                    end
                end
                ST_WAIT_REL1: begin
                    if (!cpu_ack) begin
                        state <= ST_WAIT_ACK2;
                    end
                end
                ST_WAIT_ACK2: begin
                    if (cpu_ack) begin
                        state  <= ST_WAIT_REL2;
                        bus_oe <= 1'b0;     // Vector taken.
                    end
                end
                ST_WAIT_REL2: begin
                    if (!cpu_ack) begin
                        state <= ST_WAIT_DONE;
                    end
                end
                ST_WAIT_DONE: begin
                    // A bad word also ends here, cfg_clear drops the mode meanwhile.
                    if (cpu_ack) begin
                        state <= ST_SCAN;
                    end
                end
                default: begin
                    state    <= ST_SCAN;
                    intr_out <= 1'b0;
                    bus_oe   <= 1'b0;
                end
            endcase
        end
    end

    // Served id and vector word.
    always_ff @(posedge clock_in) begin
        if (scan_en && sel.found) begin
            served_id <= sel.id;
        end
        if ((state == ST_WAIT_ACK1) && cpu_ack) begin
            bus_out.as_vec <= vec_word;
        end
    end

    // ------------------------------------------------------------------
    // Checks.
    // ------------------------------------------------------------------

    a_legal_state: assert property (@(posedge clock_in) disable iff (rst_in)
        state inside {ST_SCAN, ST_WAIT_ACK1, ST_WAIT_REL1,
                      ST_WAIT_ACK2, ST_WAIT_REL2, ST_WAIT_DONE});

    // Interrupt phase and vector phase never overlap.
    a_one_phase: assert property (@(posedge clock_in) disable iff (rst_in)
        !(intr_out && bus_oe));

    // The vector holds for the whole time it is offered.
    a_vec_stable: assert property (@(posedge clock_in) disable iff (rst_in)
        (bus_oe && $past(bus_oe)) |-> $stable(bus_out));

endmodule

/* hdl/pic_source_select.sv */
module pic_source_select
    import pic_pkg::*;
(
    input  logic             clock_in,
    input  logic             rst_in,
    input  pic_cfg_t         cfg,
    input  logic [N_SRC-1:0] intr_rq,       // Request levels.
    input  logic             scan_en,       // FSM waits in scan.
    output pic_sel_t         sel
);

    src_id_t  scan_idx;                     // Polling position.
    logic     poll_hit;                     // Request at the polling position.
    pic_sel_t prio_sel;                     // Result of the table walk.

    assign poll_hit = intr_rq[scan_idx];

    // ------------------------------------------------------------------
    // Polling scan.
    // ------------------------------------------------------------------

    // One source per scan cycle. The index parks on a hit, so after the
    // service it resumes from the source just served.
    always_ff @(posedge clock_in or posedge rst_in) begin
        if (rst_in) begin
            scan_idx <= '0;
        end else if (cfg.mode != MODE_POLL) begin
            scan_idx <= '0;                 // Fresh polling starts at source 0.
        end else if (scan_en && !poll_hit) begin
            scan_idx <= scan_idx + src_id_t'(1);    // Wraps from 7 to 0.
        end
    end

    // ------------------------------------------------------------------
    // Priority walk.
    // ------------------------------------------------------------------

    // Walk from the lowest priority up so the best active entry is kept last.
    always_comb begin
        prio_sel = '0;
        for (int i = N_SRC - 1; i >= 0; i--) begin
            if (intr_rq[cfg.prio_table[i]]) begin
                prio_sel.found = 1'b1;
                prio_sel.id    = cfg.prio_table[i];
            end
        end
    end

    // Result by mode.
    always_comb begin
        case (cfg.mode)
            MODE_POLL: begin
                sel.found = poll_hit;
                sel.id    = scan_idx;
            end
            MODE_PRIO: begin
                sel = prio_sel;
            end
            default: begin
                sel = '0;                   // Nothing to signal before a mode is set.
            end
        endcase
    end

endmodule

/* hdl/pic_config.sv */
module pic_config
    import pic_pkg::*;
(
    input  logic      clock_in,
    input  logic      rst_in,
    input  bus_word_t bus_in,               // Read through its command view.
    input  logic      cmd_valid,            // One strobe per command word.
    input  logic      cfg_clear,            // From the FSM on a bad done word.
    output pic_cfg_t  cfg
);

    cmd_word_t  cmd;                        // Strobed word as a command.
    logic       cmd_take;                   // Word is accepted this cycle.
    logic [1:0] word_cnt;                   // Priority words loaded so far.
    src_id_t    hi_slot;                    // Table slot for the high entry.
    src_id_t    lo_slot;                    // Table slot for the low entry.

    assign cmd      = bus_in.as_cmd;
    assign cmd_take = cmd_valid && (cfg.mode == MODE_NONE);   // Commands only before a mode.

    // Word n fills slots 2n and 2n+1.
    assign hi_slot = {word_cnt, 1'b0};
    assign lo_slot = {word_cnt, 1'b1};

    // ------------------------------------------------------------------
    // Command decode.
    // ------------------------------------------------------------------

    always_ff @(posedge clock_in or posedge rst_in) begin
        if (rst_in) begin
            cfg.mode       <= MODE_NONE;
            cfg.prio_table <= '0;
            word_cnt       <= '0;
        end else if (cfg_clear) begin
            // Back to command state, setup must be sent again.
            cfg.mode       <= MODE_NONE;
            cfg.prio_table <= '0;
            word_cnt       <= '0;
        end else if (cmd_take) begin
            case (cmd.cmd)
                CMD_POLL: begin
                    cfg.mode <= MODE_POLL;          // Visible the next cycle.
                    word_cnt <= '0;                 // Forget a half loaded table.
                end
                CMD_PRIO: begin
                    cfg.prio_table[hi_slot] <= cmd.hi_entry;
                    cfg.prio_table[lo_slot] <= cmd.lo_entry;
                    word_cnt                <= word_cnt + 2'd1;    // Wraps after the last pair.
                    if (word_cnt == 2'(N_CMD_WORDS - 1)) begin
                        cfg.mode <= MODE_PRIO;      // Table complete.
                    end
                end
                default: begin
                    // Unknown command, nothing changes.
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Checks.
    // ------------------------------------------------------------------

    // A set mode means every table load ran to the end or was dropped.
    a_cnt_idle: assert property (@(posedge clock_in) disable iff (rst_in)
        (cfg.mode != MODE_NONE) |-> (word_cnt == '0));

endmodule

/* hdl/pic_pkg.sv */
package pic_pkg;

    // ------------------------------------------------------------------
    // Widths and counts.
    // ------------------------------------------------------------------

    localparam int N_SRC       = 8;                 // Interrupt request lines.
    localparam int ID_W        = 3;                 // Bits in a source number.
    localparam int WORD_W      = 8;                 // Bits in a bus word.
    localparam int CODE_W      = WORD_W - ID_W;     // Code field of a vector word.
    localparam int N_CMD_WORDS = 4;                 // Priority words, two entries each.

    // ------------------------------------------------------------------
    // Command values and handshake codes.
    // ------------------------------------------------------------------

    localparam logic [1:0] CMD_POLL = 2'd1;         // Select polling mode.
    localparam logic [1:0] CMD_PRIO = 2'd2;         // Carries two table entries.

    // Codes the controller puts on outgoing vector words.
    localparam logic [CODE_W-1:0] VEC_CODE_POLL = 5'b01011;
    localparam logic [CODE_W-1:0] VEC_CODE_PRIO = 5'b10011;

    // Codes the processor must return on its done word.
    localparam logic [CODE_W-1:0] DONE_CODE_POLL = 5'b10100;
    localparam logic [CODE_W-1:0] DONE_CODE_PRIO = 5'b01100;

    // ------------------------------------------------------------------
    // Types.
    // ------------------------------------------------------------------

    typedef logic [ID_W-1:0] src_id_t;              // Source number.

    typedef enum logic [1:0] {
        MODE_NONE = 2'd0,                           // Waiting for commands.
        MODE_POLL = 2'd1,                           // Round-robin scan.
        MODE_PRIO = 2'd2                            // Table driven priority.
    } pic_mode_e;

    // Command view of a bus word. The high entry sits in the top bits.
    typedef struct packed {
        src_id_t    hi_entry;                       // Even table slot.
        src_id_t    lo_entry;                       // Odd table slot.
        logic [1:0] cmd;                            // Command field.
    } cmd_word_t;

    // Vector view, used both for outgoing vectors and for done words.
    typedef struct packed {
        logic [CODE_W-1:0] code;
        src_id_t           id;
    } vec_word_t;

    // One bus word, read as a command while configuring, as a vector in service.
    typedef union packed {
        cmd_word_t as_cmd;
        vec_word_t as_vec;
    } bus_word_t;

    typedef struct packed {
        pic_mode_e             mode;
        src_id_t [N_SRC-1:0]   prio_table;          // Entry 0 is the highest priority.
    } pic_cfg_t;

    typedef struct packed {
        logic    found;                             // A source is ready to be signalled.
        src_id_t id;
    } pic_sel_t;

endpackage
